// ==== sim.f ====
neighbor_mem_pkg.sv
edge_pe_pkg.sv
neighbor_ifs.sv
neighbor_req_fifo.sv
neighbor_dispatch.sv
neighbor_bank_ctl.sv
neighbor_sram.sv
pe_crossbar.sv
neighbor_fetch_top.sv
neighbor_checker.sv
tb_neighbor_fetch.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_neighbor_fetch -f sim.f
./obj_dir/Vtb_neighbor_fetch 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
# a run that aborted early prints neither message
grep -q "test passed" sim.log

// ==== tb_neighbor_fetch.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_neighbor_fetch;
    import neighbor_mem_pkg::*;
    import edge_pe_pkg::*;

    localparam int LOAD_WORDS     = NUM_BANKS * (1 << ROW_W);
    localparam int EARLY_REQS     = 2;
    localparam int BURST_REQS     = 40;
    localparam int RAND_REQS      = 160;
    localparam int NUM_REQS       = EARLY_REQS + BURST_REQS + RAND_REQS;
    localparam int TIMEOUT_CYCLES = LOAD_WORDS + NUM_REQS * 20 + 500;

    logic                  clk;
    logic                  reset;
    logic                  wdata_valid;
    nbr_addr_t             wdata_addr;
    degree_t               wdata_degree;
    pe_tag_t               wdata_pe_tag;
    logic                  load_valid;
    nbr_addr_t             load_addr;
    id_t                   load_data;
    logic [NUM_PE-1:0]     pe_valid;
    logic [NUM_PE-1:0]     pe_sos;
    logic [NUM_PE-1:0]     pe_eos;
    iter_t [NUM_PE-1:0]    pe_iter;
    id_t [NUM_PE-1:0]      pe_id;
    logic                  wfull;

    int          mismatch_count;
    int          fault_count;
    int          pending;
    int          tb_faults;
    int          cycles;
    logic        saw_full;
    logic [31:0] lfsr;

    neighbor_fetch_top #(.FIFO_DEPTH(8), .ROWS(256)) dut (
        .clk          (clk),
        .reset        (reset),
        .wdata_valid  (wdata_valid),
        .wdata_addr   (wdata_addr),
        .wdata_degree (wdata_degree),
        .wdata_pe_tag (wdata_pe_tag),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .pe_valid     (pe_valid),
        .pe_sos       (pe_sos),
        .pe_eos       (pe_eos),
        .pe_iter      (pe_iter),
        .pe_id        (pe_id),
        .wfull        (wfull)
    );

    neighbor_checker u_checker (
        .clk            (clk),
        .reset          (reset),
        .wdata_valid    (wdata_valid),
        .wdata_addr     (wdata_addr),
        .wdata_degree   (wdata_degree),
        .wdata_pe_tag   (wdata_pe_tag),
        .wfull          (wfull),
        .load_valid     (load_valid),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .pe_valid       (pe_valid),
        .pe_sos         (pe_sos),
        .pe_eos         (pe_eos),
        .pe_iter        (pe_iter),
        .pe_id          (pe_id),
        .mismatch_count (mismatch_count),
        .fault_count    (fault_count),
        .pending        (pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic load_all();
        for (int a = 0; a < LOAD_WORDS; a++) begin
            @(negedge clk);
            load_valid = 1'b1;
            load_addr  = nbr_addr_t'(a);
            load_data  = id_t'(take_bits(ID_W));
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    // holds the request until wfull is low, accepted at the next rising edge
    task automatic send_req(input bank_idx_t bank, input row_t row, input degree_t deg,
                            input pe_tag_t tag);
        @(negedge clk);
        wdata_valid  = 1'b1;
        wdata_addr   = {bank, row};
        wdata_degree = deg;
        wdata_pe_tag = tag;
        while (wfull) begin
            saw_full = 1'b1;
            @(negedge clk);
        end
    endtask

    task automatic send_random(input bank_idx_t bank, input pe_tag_t tag);
        degree_t deg;
        int      row;
        deg = degree_t'(take_bits(4) + 1);
        row = int'(take_bits(ROW_W));
        if (row + int'(deg) > (1 << ROW_W)) row = (1 << ROW_W) - int'(deg);   // stay in bank
        send_req(bank, row_t'(row), deg, tag);
    endtask

    task automatic end_requests();
        @(negedge clk);
        wdata_valid = 1'b0;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d streams still pending", cycles, pending);
        $display("errors: mismatch %0d other %0d", mismatch_count, fault_count + tb_faults + 1);
        $display("test failed");
        $finish;
    end

    initial begin
        bank_idx_t rb;
        pe_tag_t   rt;
        lfsr         = 32'h7840_4c36;
        reset        = 1'b1;
        wdata_valid  = 1'b0;
        wdata_addr   = '0;
        wdata_degree = '0;
        wdata_pe_tag = '0;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        tb_faults    = 0;
        saw_full     = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);

        load_all();

        // early reads, last rows of one bank and a full-degree read of another
        send_req(2'd2, 8'd250, 5'd6, 2'd1);
        send_req(2'd0, 8'd0, 5'd16, 2'd3);

        for (int i = 0; i < BURST_REQS; i++) begin
            send_random(2'd1, 2'd2);   // one bank, one PE
        end
        for (int i = 0; i < RAND_REQS; i++) begin
            rb = bank_idx_t'(take_bits(BANK_W));
            rt = pe_tag_t'(take_bits(2));
            send_random(rb, rt);
        end
        end_requests();

        if (!saw_full) begin
            $display("wfull never went high during the single bank burst");
            tb_faults++;
        end

        while (pending != 0) @(negedge clk);
        repeat (40) @(negedge clk);   // catch stray words

        $display("errors: mismatch %0d other %0d", mismatch_count, fault_count + tb_faults);
        if (mismatch_count == 0 && fault_count + tb_faults == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== neighbor_checker.sv ====
`default_nettype none
`timescale 1ns/1ns

module neighbor_checker (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            wdata_valid,
    input  neighbor_mem_pkg::nbr_addr_t                     wdata_addr,
    input  edge_pe_pkg::degree_t                            wdata_degree,
    input  edge_pe_pkg::pe_tag_t                            wdata_pe_tag,
    input  logic                                            wfull,
    input  logic                                            load_valid,
    input  neighbor_mem_pkg::nbr_addr_t                     load_addr,
    input  neighbor_mem_pkg::id_t                           load_data,
    input  logic [edge_pe_pkg::NUM_PE-1:0]                  pe_valid,
    input  logic [edge_pe_pkg::NUM_PE-1:0]                  pe_sos,
    input  logic [edge_pe_pkg::NUM_PE-1:0]                  pe_eos,
    input  edge_pe_pkg::iter_t [edge_pe_pkg::NUM_PE-1:0]    pe_iter,
    input  neighbor_mem_pkg::id_t [edge_pe_pkg::NUM_PE-1:0] pe_id,
    output int                                              mismatch_count,
    output int                                              fault_count,
    output int                                              pending
);
    import neighbor_mem_pkg::*;
    import edge_pe_pkg::*;

    localparam int QD    = 256;   // per-PE request slots, never wraps in one run
    localparam int WORDS = NUM_BANKS * (1 << ROW_W);

    id_t       mirror [WORDS];
    nbr_addr_t q_addr [NUM_PE][QD];
    degree_t   q_deg  [NUM_PE][QD];
    int        q_wr   [NUM_PE];
    int        q_rd   [NUM_PE];
    int        pos    [NUM_PE];   // word index inside the open stream
    int        accepted;
    int        rd;
    id_t       exp_id;
    degree_t   exp_deg;
    logic      exp_sos;
    logic      exp_eos;

    always @(posedge clk) begin
        if (reset) begin
            mismatch_count = 0;
            fault_count    = 0;
            pending        = 0;
            accepted       = 0;
            for (int p = 0; p < NUM_PE; p++) begin
                q_wr[p] = 0;
                q_rd[p] = 0;
                pos[p]  = 0;
            end
        end else begin
            // nothing may come out before the first request
            if (accepted == 0 && ({pe_valid, pe_sos, pe_eos} != '0 || wfull)) begin
                $display("MISMATCH idle outputs pe_valid %h pe_sos %h pe_eos %h wfull %h, expected 0",
                         pe_valid, pe_sos, pe_eos, wfull);
                mismatch_count++;
            end

            for (int p = 0; p < NUM_PE; p++) begin
                if (pe_valid[p]) begin
                    if (q_rd[p] == q_wr[p]) begin
                        $display("PE %0d received a word with no request pending", p);
                        fault_count++;
                    end else begin
                        rd      = q_rd[p];
                        exp_deg = q_deg[p][rd];
                        exp_id  = mirror[int'(q_addr[p][rd]) + pos[p]];
                        exp_sos = (pos[p] == 0);
                        exp_eos = (pos[p] == int'(exp_deg) - 1);
                        if (pe_id[p] !== exp_id) begin
                            $display("MISMATCH pe_id[%0d] got %h expected %h", p, pe_id[p], exp_id);
                            mismatch_count++;
                        end
                        if (pe_iter[p] !== iter_t'(pos[p])) begin
                            $display("MISMATCH pe_iter[%0d] got %h expected %h",
                                     p, pe_iter[p], iter_t'(pos[p]));
                            mismatch_count++;
                        end
                        if (pe_sos[p] !== exp_sos) begin
                            $display("MISMATCH pe_sos[%0d] got %h expected %h", p, pe_sos[p], exp_sos);
                            mismatch_count++;
                        end
                        if (pe_eos[p] !== exp_eos) begin
                            $display("MISMATCH pe_eos[%0d] got %h expected %h", p, pe_eos[p], exp_eos);
                            mismatch_count++;
                        end
                        if (exp_eos) begin
                            q_rd[p]++;
                            pos[p] = 0;
                            pending--;
                        end else begin
                            pos[p]++;
                        end
                    end
                end else if (pe_sos[p] || pe_eos[p]) begin
                    $display("PE %0d raised a stream marker without valid", p);
                    fault_count++;
                end
            end

            if (wdata_valid && !wfull) begin
                q_addr[wdata_pe_tag][q_wr[wdata_pe_tag]] = wdata_addr;
                q_deg[wdata_pe_tag][q_wr[wdata_pe_tag]]  = wdata_degree;
                q_wr[wdata_pe_tag]++;
                pending++;
                accepted++;
            end

            if (load_valid) mirror[load_addr] = load_data;
        end
    end

endmodule

`default_nettype wire

// ==== neighbor_fetch_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module neighbor_fetch_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int ROWS       = 256
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         wdata_valid,
    input  neighbor_mem_pkg::nbr_addr_t                  wdata_addr,
    input  edge_pe_pkg::degree_t                         wdata_degree,
    input  edge_pe_pkg::pe_tag_t                         wdata_pe_tag,
    input  logic                                         load_valid,
    input  neighbor_mem_pkg::nbr_addr_t                  load_addr,
    input  neighbor_mem_pkg::id_t                        load_data,
    output logic [edge_pe_pkg::NUM_PE-1:0]               pe_valid,
    output logic [edge_pe_pkg::NUM_PE-1:0]               pe_sos,
    output logic [edge_pe_pkg::NUM_PE-1:0]               pe_eos,
    output edge_pe_pkg::iter_t [edge_pe_pkg::NUM_PE-1:0] pe_iter,
    output neighbor_mem_pkg::id_t [edge_pe_pkg::NUM_PE-1:0] pe_id,
    output logic                                         wfull
);
    import neighbor_mem_pkg::*;
    import edge_pe_pkg::*;

    logic [REQ_W-1:0] req_word;
    logic [REQ_W-1:0] head;
    logic             empty;
    logic             rinc;

    bank_req_if  breq  [NUM_BANKS] ();
    sram_port_if sport [NUM_BANKS] ();
    pe_stream_if pstrm [NUM_BANKS] ();

    assign req_word = {wdata_addr, wdata_degree, wdata_pe_tag};

    neighbor_req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk    (clk),
        .reset  (reset),
        .winc   (wdata_valid),
        .wdata  (req_word),
        .rinc   (rinc),
        .rdata  (head),
        .wfull  (wfull),
        .rempty (empty)
    );

    neighbor_dispatch u_dispatch (
        .clk     (clk),
        .reset   (reset),
        .head    (head),
        .empty   (empty),
        .rinc    (rinc),
        .banks   (breq),
        .pe_done (pe_eos)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        neighbor_bank_ctl #(.BANK_ID(b), .ROWS(ROWS)) u_bank_ctl (
            .clk        (clk),
            .reset      (reset),
            .req        (breq[b]),
            .mem        (sport[b]),
            .strm       (pstrm[b]),
            .load_valid (load_valid),
            .load_addr  (load_addr),
            .load_data  (load_data)
        );

        neighbor_sram #(.ROWS(ROWS)) u_sram (
            .clk  (clk),
            .port (sport[b])
        );
    end

    pe_crossbar u_xbar (
        .clk      (clk),
        .reset    (reset),
        .strm     (pstrm),
        .pe_valid (pe_valid),
        .pe_sos   (pe_sos),
        .pe_eos   (pe_eos),
        .pe_iter  (pe_iter),
        .pe_id    (pe_id)
    );

endmodule

`default_nettype wire

// ==== pe_crossbar.sv ====
`default_nettype none
`timescale 1ns/1ns

module pe_crossbar (
    input  logic                                         clk,
    input  logic                                         reset,
    pe_stream_if.sink                                    strm [neighbor_mem_pkg::NUM_BANKS],
    output logic [edge_pe_pkg::NUM_PE-1:0]               pe_valid,
    output logic [edge_pe_pkg::NUM_PE-1:0]               pe_sos,
    output logic [edge_pe_pkg::NUM_PE-1:0]               pe_eos,
    output edge_pe_pkg::iter_t [edge_pe_pkg::NUM_PE-1:0] pe_iter,
    output neighbor_mem_pkg::id_t [edge_pe_pkg::NUM_PE-1:0] pe_id
);
    import neighbor_mem_pkg::*;
    import edge_pe_pkg::*;

    logic    [NUM_BANKS-1:0] b_valid;
    logic    [NUM_BANKS-1:0] b_sos;
    logic    [NUM_BANKS-1:0] b_eos;
    pe_tag_t [NUM_BANKS-1:0] b_tag;
    iter_t   [NUM_BANKS-1:0] b_iter;
    id_t     [NUM_BANKS-1:0] b_id;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign b_valid[b] = strm[b].valid;
        assign b_sos[b]   = strm[b].sos;
        assign b_eos[b]   = strm[b].eos;
        assign b_tag[b]   = strm[b].pe_tag;
        assign b_iter[b]  = strm[b].iter;
        assign b_id[b]    = strm[b].id;
    end

    for (genvar p = 0; p < NUM_PE; p++) begin : g_lane
        logic [NUM_BANKS-1:0] hit;
        iter_t sel_iter;
        id_t   sel_id;
        logic  v_q;
        logic  s_q;
        logic  e_q;
        iter_t iter_q;
        id_t   id_q;

        always_comb begin
            sel_iter = '0;
            sel_id   = '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                hit[b] = b_valid[b] && (b_tag[b] == pe_tag_t'(p));
                if (hit[b]) begin
                    sel_iter = b_iter[b];
                    sel_id   = b_id[b];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                v_q <= 1'b0;
                s_q <= 1'b0;
                e_q <= 1'b0;
            end else begin
                v_q <= |hit;
                s_q <= |(hit & b_sos);
                e_q <= |(hit & b_eos);  // doubles as pe_done
            end
        end

        always_ff @(posedge clk) begin
            iter_q <= sel_iter;
            id_q   <= sel_id;
        end

        assign pe_valid[p] = v_q;
        assign pe_sos[p]   = s_q;
        assign pe_eos[p]   = e_q;
        assign pe_iter[p]  = iter_q;
        assign pe_id[p]    = id_q;

        // dispatcher lets one stream per PE run at a time
        a_one_bank: assert property (@(posedge clk) disable iff (reset) $onehot0(hit));
    end

endmodule

`default_nettype wire

// ==== neighbor_sram.sv ====
`default_nettype none
`timescale 1ns/1ns

module neighbor_sram #(
    parameter int ROWS = 256
) (
    input  logic      clk,
    sram_port_if.slave port
);
    import neighbor_mem_pkg::*;

    id_t ram [ROWS];
    id_t q_r;

    always_ff @(posedge clk) begin
        if (!port.cen) begin
            if (!port.wen) begin
                ram[port.a] <= port.d;   // write
            end else begin
                q_r <= ram[port.a];      // read, q next cycle
            end
        end
    end

    assign port.q = q_r;

endmodule

`default_nettype wire

// ==== neighbor_bank_ctl.sv ====
`default_nettype none
`timescale 1ns/1ns

module neighbor_bank_ctl #(
    parameter int BANK_ID = 0,
    parameter int ROWS    = 256
) (
    input  logic                       clk,
    input  logic                       reset,
    bank_req_if.sink                   req,
    sram_port_if.master                mem,
    pe_stream_if.source                strm,
    input  logic                       load_valid,
    input  neighbor_mem_pkg::nbr_addr_t load_addr,
    input  neighbor_mem_pkg::id_t      load_data
);
    import neighbor_mem_pkg::*;
    import edge_pe_pkg::*;

    typedef enum logic {IDLE, READ} state_t;

    state_t    state_q;
    row_t      row_q;
    iter_t     cnt_q;
    iter_t     last_q;
    pe_tag_t   tag_q;
    logic      out_vld_q;
    logic      out_sos_q;
    logic      out_eos_q;
    iter_t     out_iter_q;

    bank_idx_t req_bank;
    row_t      req_row;
    bank_idx_t load_bank;
    row_t      load_row;
    logic      load_hit;
    logic      reading;

    assign {req_bank, req_row}   = req.addr;
    assign {load_bank, load_row} = load_addr;
    assign load_hit = load_valid && (load_bank == bank_idx_t'(BANK_ID));
    assign reading  = (state_q == READ);
    assign req.busy = reading;  // drops once the last read is out

    always_comb begin
        mem.cen = 1'b1;
        mem.wen = 1'b1;
        mem.a   = row_q;
        mem.d   = load_data;
        if (reading) begin
            mem.cen = 1'b0;
        end else if (load_hit) begin
            mem.cen = 1'b0;
            mem.wen = 1'b0;
            mem.a   = load_row;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= IDLE;
            out_vld_q <= 1'b0;
            out_sos_q <= 1'b0;
            out_eos_q <= 1'b0;
        end else begin
            // lines up with q, one cycle behind the read
            out_vld_q <= reading;
            out_sos_q <= reading && (cnt_q == '0);
            out_eos_q <= reading && (cnt_q == last_q);
            case (state_q)
                IDLE:    if (req.valid) state_q <= READ;
                READ:    if (cnt_q == last_q) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        out_iter_q <= cnt_q;
        if (!reading && req.valid) begin
            row_q  <= req_row;
            cnt_q  <= '0;
            last_q <= iter_t'(req.degree - 1'b1);
            tag_q  <= req.pe_tag;
        end else if (reading) begin
            row_q <= row_q + 1'b1;
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign strm.valid  = out_vld_q;
    assign strm.sos    = out_sos_q;
    assign strm.eos    = out_eos_q;
    assign strm.iter   = out_iter_q;
    assign strm.id     = mem.q;
    assign strm.pe_tag = tag_q;   // stable until the next request lands

    // no read may run past the end of the bank
    a_in_bank: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> (req.degree != '0) && (int'(req.degree) <= MAX_DEGREE)
                      && (int'(req_row) + int'(req.degree) <= ROWS));

    a_routed: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> req_bank == bank_idx_t'(BANK_ID));

endmodule

`default_nettype wire

// ==== neighbor_dispatch.sv ====
`default_nettype none
`timescale 1ns/1ns

module neighbor_dispatch (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [edge_pe_pkg::REQ_W-1:0] head,
    input  logic                          empty,
    output logic                          rinc,
    bank_req_if.source                    banks [neighbor_mem_pkg::NUM_BANKS],
    input  logic [edge_pe_pkg::NUM_PE-1:0] pe_done
);
    import neighbor_mem_pkg::*;
    import edge_pe_pkg::*;

    nbr_addr_t head_addr;
    degree_t   head_deg;
    pe_tag_t   head_tag;
    bank_idx_t bank_sel;

    logic [NUM_BANKS-1:0] bank_busy;
    logic [NUM_BANKS-1:0] bank_block;
    logic [NUM_BANKS-1:0] bank_onehot;
    logic [NUM_PE-1:0]    pe_onehot;
    logic [NUM_PE-1:0]    pe_busy;
    logic [NUM_BANKS-1:0] valid_q;
    logic                 go;

    nbr_addr_t iss_addr;
    degree_t   iss_deg;
    pe_tag_t   iss_tag;

    assign {head_addr, head_deg, head_tag} = head;
    assign bank_sel = head_addr[ADDR_W-1:ROW_W];

    // bank only raises busy a cycle after the pulse, so the pulse blocks too
    assign bank_block = bank_busy | valid_q;
    assign go   = !empty && !bank_block[bank_sel] && !pe_busy[head_tag];
    assign rinc = go;

    always_comb begin
        bank_onehot = '0;
        pe_onehot   = '0;
        bank_onehot[bank_sel] = go;
        pe_onehot[head_tag]   = go;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            pe_busy <= '0;
        end else begin
            valid_q <= bank_onehot;
            pe_busy <= (pe_busy & ~pe_done) | pe_onehot;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            iss_addr <= head_addr;
            iss_deg  <= head_deg;
            iss_tag  <= head_tag;
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign bank_busy[b]    = banks[b].busy;
        assign banks[b].valid  = valid_q[b];
        assign banks[b].addr   = iss_addr;
        assign banks[b].degree = iss_deg;
        assign banks[b].pe_tag = iss_tag;
    end

    // eos from the crossbar only for a PE with an open stream
    a_done_busy: assert property (@(posedge clk) disable iff (reset)
        (pe_done & ~pe_busy) == '0);

    a_bank_free: assert property (@(posedge clk) disable iff (reset)
        (valid_q & bank_busy) == '0);

endmodule

`default_nettype wire

// ==== neighbor_req_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

module neighbor_req_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         winc,
    input  logic [edge_pe_pkg::REQ_W-1:0] wdata,
    input  logic                         rinc,
    output logic [edge_pe_pkg::REQ_W-1:0] rdata,
    output logic                         wfull,
    output logic                         rempty
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = AW + 1;

    logic [edge_pe_pkg::REQ_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0] wptr;
    logic [AW-1:0] rptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        if (p == AW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign do_wr  = winc && !wfull;   // offered while full is dropped
    assign do_rd  = rinc && !rempty;
    assign wfull  = (count == CW'(FIFO_DEPTH));
    assign rempty = (count == '0);
    assign rdata  = mem[rptr];        // head is always visible

    always_ff @(posedge clk) begin
        if (reset) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) wptr <= next_ptr(wptr);
            if (do_rd) rptr <= next_ptr(rptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wptr] <= wdata;
    end

    // dispatcher must only pop a non-empty queue
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) rinc |-> !rempty);

endmodule

`default_nettype wire

// ==== neighbor_ifs.sv ====
`default_nettype none
`timescale 1ns/1ns

// dispatcher to bank, one per bank
interface bank_req_if;
    import neighbor_mem_pkg::*;
    import edge_pe_pkg::*;

    logic      valid;   // one cycle pulse
    nbr_addr_t addr;
    degree_t   degree;
    pe_tag_t   pe_tag;
    logic      busy;

    modport source (output valid, addr, degree, pe_tag, input busy);
    modport sink   (input valid, addr, degree, pe_tag, output busy);
endinterface

// bank to crossbar stream, no back-pressure
interface pe_stream_if;
    import neighbor_mem_pkg::*;
    import edge_pe_pkg::*;

    logic    valid;
    logic    sos;
    logic    eos;
    iter_t   iter;
    id_t     id;
    pe_tag_t pe_tag;

    modport source (output valid, sos, eos, iter, id, pe_tag);
    modport sink   (input valid, sos, eos, iter, id, pe_tag);
endinterface

// bank controller to SRAM, enables active low
interface sram_port_if;
    import neighbor_mem_pkg::*;

    logic cen;
    logic wen;
    row_t a;
    id_t  d;
    id_t  q;    // one cycle after read

    modport master (output cen, wen, a, d, input q);
    modport slave  (input cen, wen, a, d, output q);
endinterface

`default_nettype wire

// ==== edge_pe_pkg.sv ====
`default_nettype none

package edge_pe_pkg;

    localparam int NUM_PE     = 4;
    localparam int MAX_DEGREE = 16;

    localparam int TAG_W  = 2;
    localparam int DEG_W  = 5;  // holds 1..16
    localparam int ITER_W = 4;  // holds 0..15

    typedef logic [TAG_W-1:0]  pe_tag_t;
    typedef logic [DEG_W-1:0]  degree_t;
    typedef logic [ITER_W-1:0] iter_t;

    // packed request word {addr, degree, pe_tag}
    localparam int REQ_W = $bits(neighbor_mem_pkg::nbr_addr_t) + DEG_W + TAG_W;

endpackage

`default_nettype wire

// ==== neighbor_mem_pkg.sv ====
`default_nettype none

package neighbor_mem_pkg;

    // bank geometry
    localparam int NUM_BANKS = 4;
    localparam int BANK_W    = 2;   // log2 of NUM_BANKS
    localparam int ROW_W     = 8;   // 256 rows per bank

    // neighbor id word, same width as the SRAM macro
    localparam int ID_W = 14;

    // full neighbor address is bank then row
    localparam int ADDR_W = BANK_W + ROW_W;

    typedef logic [BANK_W-1:0] bank_idx_t;
    typedef logic [ROW_W-1:0]  row_t;
    typedef logic [ID_W-1:0]   id_t;

    // {bank, row}
    typedef logic [ADDR_W-1:0] nbr_addr_t;

endpackage

`default_nettype wire
